/* board_ctrl_top.f */
common/board_ctrl_pkg.sv
verilog/spi_reg_port/spi_shifter.sv
verilog/spi_reg_port/spi_frame_ctrl.sv
verilog/reg_file.sv
verilog/led_blinker.sv
verilog/board_ctrl_top.sv
test/tb_board_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the board control testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f board_ctrl_top.f --top-module tb_board_ctrl \
    -Mdir obj_dir -o tb_board_ctrl > build.log 2>&1 \
    || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/tb_board_ctrl > sim.log 2>&1 \
    || echo "simulator returned an error status"

cat sim.log

grep -q "TEST RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

/* test/tb_board_ctrl.sv */
//--------------------
// board control testbench
// random spi frames checked against a register model
//--------------------
`timescale 1ns/10ps
`default_nettype none

module tb_board_ctrl
    import board_ctrl_pkg::*;
();

    localparam int SCLK_HALF    = 8;   // reg_clk cycles per sclk half period
    localparam int N_PAIRS      = 60;
    localparam int N_BAD_WR     = 12;
    localparam int N_ABORT      = 10;
    localparam int N_PIN        = 16;
    localparam int FRAME_CYCLES = FRAME_BITS * 2 * SCLK_HALF + 3 * SCLK_HALF;
    // reset reads, pairs, bad writes, sweep, mdio reads, aborts
    localparam int N_FRAMES     = 7 + 2 * N_PAIRS + 2 * N_BAD_WR + 24 + 4 + 2 * N_ABORT;
    localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 3 * LED_HALF_PERIOD
                                    + 2 * N_PIN + 2000;

    logic                 reg_clk;
    logic                 arst_n_i;
    logic                 spi_sclk_i;
    logic [1:0]           spi_cs_i;
    logic                 spi_mosi_i;
    logic                 flash_miso_i;
    logic [TEMP_W-1:0]    temp_i;
    logic [ETH_PORTS-1:0] link_i;
    logic                 mdio_i;
    logic                 spi_miso_o;
    logic                 flash_cs_o;
    logic                 flash_mosi_o;
    logic [ETH_PORTS-1:0] eth_phy_rst_o;
    logic                 mdc_o;
    logic                 mdio_o;
    logic                 mdio_oe_o;
    logic                 dbg_led_o;

    logic [REG_DW-1:0] model_mem [0:(1<<REG_AW)-1];  // register model
    integer            seed;
    int                err_cnt;
    int                chk_cnt;
    int                test_cnt;
    int                test_err0;
    int                cycle_cnt = 0;

    board_ctrl_top i_dut (
        .reg_clk       (reg_clk),
        .arst_n_i      (arst_n_i),
        .spi_sclk_i    (spi_sclk_i),
        .spi_cs_i      (spi_cs_i),
        .spi_mosi_i    (spi_mosi_i),
        .flash_miso_i  (flash_miso_i),
        .temp_i        (temp_i),
        .link_i        (link_i),
        .mdio_i        (mdio_i),
        .spi_miso_o    (spi_miso_o),
        .flash_cs_o    (flash_cs_o),
        .flash_mosi_o  (flash_mosi_o),
        .eth_phy_rst_o (eth_phy_rst_o),
        .mdc_o         (mdc_o),
        .mdio_o        (mdio_o),
        .mdio_oe_o     (mdio_oe_o),
        .dbg_led_o     (dbg_led_o)
    );

    initial reg_clk = 1'b0;
    always #5 reg_clk = ~reg_clk;

    // run limit
    always @(posedge reg_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped, tests did not finish within %0d cycles", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //--------------------
    // compare tasks
    //--------------------
    task automatic check_reg(input string name, input logic [REG_DW-1:0] got,
                             input logic [REG_DW-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_phy(input phy_ctrl_t got, input phy_ctrl_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            if (got.phy_rst !== exp.phy_rst)
                $display("FAILED eth_phy_rst_o: got 0x%h, expected 0x%h",
                         got.phy_rst, exp.phy_rst);
            if (got.mdc !== exp.mdc)
                $display("FAILED mdc_o: got 0x%h, expected 0x%h", got.mdc, exp.mdc);
            if (got.mdio_out !== exp.mdio_out)
                $display("FAILED mdio_o: got 0x%h, expected 0x%h", got.mdio_out, exp.mdio_out);
            if (got.mdio_oe !== exp.mdio_oe)
                $display("FAILED mdio_oe_o: got 0x%h, expected 0x%h", got.mdio_oe, exp.mdio_oe);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    //--------------------
    // register model
    //--------------------
    function automatic logic is_writable(input logic [REG_AW-1:0] addr);
        return (addr >= RA_PHY_RST && addr <= RA_MDIO_DIR) ||
               (addr >= RA_TEST_BASE && int'(addr) < int'(RA_TEST_BASE) + TEST_ARRAY_LEN);
    endfunction

    task automatic model_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
        case (addr)
            RA_PHY_RST: model_mem[addr] = {{(REG_DW-ETH_PORTS){1'b0}}, data[ETH_PORTS-1:0]};
            RA_MDC, RA_MDIO_OUT, RA_MDIO_DIR: model_mem[addr] = {{(REG_DW-1){1'b0}}, data[0]};
            default: begin
                if (is_writable(addr)) begin
                    model_mem[addr] = data;  // test array
                end
            end
        endcase
    endtask

    function automatic logic [REG_DW-1:0] expected_read(input logic [REG_AW-1:0] addr);
        case (addr)
            RA_FW_DATE_LO: return FW_DATE[15:0];
            RA_FW_DATE_HI: return FW_DATE[31:16];
            RA_FW_TIME_LO: return FW_TIME[15:0];
            RA_FW_TIME_HI: return FW_TIME[31:16];
            RA_FW_TYPE:    return FW_TYPE;
            RA_TEMP:       return {{(REG_DW-TEMP_W){1'b0}}, temp_i};
            RA_LINK:       return {{(REG_DW-ETH_PORTS){1'b0}}, link_i};
            RA_MDIO_IN:    return {{(REG_DW-1){1'b0}}, mdio_i};
            default:       return is_writable(addr) ? model_mem[addr] : '0;
        endcase
    endfunction

    function automatic phy_ctrl_t expected_phy();
        return '{phy_rst: model_mem[RA_PHY_RST][ETH_PORTS-1:0], mdc: model_mem[RA_MDC][0],
                 mdio_out: model_mem[RA_MDIO_OUT][0], mdio_oe: model_mem[RA_MDIO_DIR][0]};
    endfunction

    function automatic phy_ctrl_t pins_phy();
        return '{phy_rst: eth_phy_rst_o, mdc: mdc_o, mdio_out: mdio_o, mdio_oe: mdio_oe_o};
    endfunction

    //--------------------
    // spi master
    //--------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge reg_clk);
    endtask

    // mode 0, nbits below FRAME_BITS gives an aborted frame
    task automatic spi_frame(input logic [CMD_BITS-1:0] cmd, input logic [DATA_BITS-1:0] data,
                             input int nbits, output logic [DATA_BITS-1:0] rd_data);
        logic [FRAME_BITS-1:0] frame;
        int                    i;
        frame   = {cmd, data};
        rd_data = '0;
        spi_cs_i[1] = 1'b0;
        wait_cycles(SCLK_HALF);
        for (i = 0; i < nbits; i++) begin
            spi_mosi_i = frame[FRAME_BITS-1-i];
            wait_cycles(SCLK_HALF);
            if (i >= CMD_BITS) begin
                rd_data[FRAME_BITS-1-i] = spi_miso_o;  // sampled at the rise
            end
            spi_sclk_i = 1'b1;
            wait_cycles(SCLK_HALF);
            spi_sclk_i = 1'b0;
        end
        wait_cycles(SCLK_HALF);
        spi_cs_i[1] = 1'b1;
        spi_mosi_i  = 1'b0;
        wait_cycles(SCLK_HALF);
    endtask

    task automatic spi_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
        logic [DATA_BITS-1:0] unused;
        spi_frame({1'b0, addr}, data, FRAME_BITS, unused);
    endtask

    task automatic read_check(input logic [REG_AW-1:0] addr);
        logic [DATA_BITS-1:0] got;
        spi_frame({1'b1, addr}, '0, FRAME_BITS, got);
        check_reg($sformatf("rd_data 0x%h", addr), got, expected_read(addr));
    endtask

    task automatic random_inputs();
        temp_i = TEMP_W'($random(seed));
        link_i = ETH_PORTS'($random(seed));
        mdio_i = 1'($random(seed));
    endtask

    // one of the twelve writable registers
    task automatic pick_writable(output logic [REG_AW-1:0] addr);
        int idx;
        idx  = $unsigned($random(seed)) % 12;
        addr = (idx < 4) ? REG_AW'(RA_PHY_RST + idx) : REG_AW'(RA_TEST_BASE + idx - 4);
    endtask

    task automatic begin_test();
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
        end
    endtask

    //--------------------
    // tests
    //--------------------
    // starts right at reset release, led state follows the cycle count
    task automatic test_led();
        int   k;
        logic exp;
        begin_test();
        for (k = 1; k <= 3 * LED_HALF_PERIOD + 4; k++) begin
            wait_cycles(1);
            exp = ((k / LED_HALF_PERIOD) % 2) == 1;
            check_bit("dbg_led_o", dbg_led_o, exp);
        end
        end_test("led blink");
    endtask

    task automatic test_reset_reads();
        int a;
        begin_test();
        check_bit("spi_miso_o", spi_miso_o, 1'b1);  // idle level
        check_phy(pins_phy(), expected_phy());
        for (a = RA_FW_DATE_LO; a <= RA_LINK; a++) begin
            random_inputs();
            read_check(REG_AW'(a));
        end
        end_test("reset values");
    endtask

    task automatic test_write_read();
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
        int                n;
        begin_test();
        for (n = 0; n < N_PAIRS; n++) begin
            pick_writable(addr);
            data = REG_DW'($random(seed));
            random_inputs();
            spi_write(addr, data);
            model_write(addr, data);
            read_check(addr);
            check_phy(pins_phy(), expected_phy());
        end
        end_test("write and read back");
    endtask

    task automatic test_bad_writes();
        logic [REG_AW-1:0] addr;
        int                idx;
        int                n;
        begin_test();
        for (n = 0; n < N_BAD_WR; n++) begin
            if (n % 2 == 0) begin
                idx  = $unsigned($random(seed)) % 8;  // read-only set
                addr = (idx < 7) ? REG_AW'(idx) : RA_MDIO_IN;
            end else begin
                addr = REG_AW'($random(seed));
                while (is_writable(addr)) begin
                    addr = REG_AW'($random(seed));
                end
            end
            spi_write(addr, REG_DW'($random(seed)));
            model_write(addr, REG_DW'($random(seed)));  // must be ignored
            read_check(addr);
            check_phy(pins_phy(), expected_phy());
        end
        for (n = 0; n < int'(RA_TEST_BASE) + TEST_ARRAY_LEN; n++) begin
            read_check(REG_AW'(n));
        end
        for (n = 0; n < 4; n++) begin
            mdio_i = n[0];
            read_check(RA_MDIO_IN);
        end
        end_test("read-only and unmapped");
    endtask

    task automatic test_abort();
        logic [REG_AW-1:0]    addr;
        logic [DATA_BITS-1:0] unused;
        int                   nbits;
        int                   n;
        begin_test();
        for (n = 0; n < N_ABORT; n++) begin
            pick_writable(addr);
            nbits = 1 + $unsigned($random(seed)) % (FRAME_BITS - 1);
            spi_frame({1'b0, addr}, ~model_mem[addr], nbits, unused);
            read_check(addr);
            check_phy(pins_phy(), expected_phy());
        end
        end_test("aborted frames");
    endtask

    task automatic test_flash_miso();
        int n;
        begin_test();
        for (n = 0; n < N_PIN; n++) begin
            spi_cs_i     = 2'b10;  // flash selected
            spi_mosi_i   = 1'($random(seed));
            flash_miso_i = 1'($random(seed));
            wait_cycles(1);
            check_bit("flash_cs_o", flash_cs_o, 1'b0);
            check_bit("flash_mosi_o", flash_mosi_o, spi_mosi_i);
            check_bit("spi_miso_o", spi_miso_o, flash_miso_i);
            spi_cs_i     = 2'b11;
            flash_miso_i = 1'($random(seed));
            wait_cycles(1);
            check_bit("flash_cs_o", flash_cs_o, 1'b1);
            check_bit("spi_miso_o", spi_miso_o, 1'b1);
        end
        spi_mosi_i = 1'b0;
        end_test("flash miso sharing");
    endtask

    //--------------------
    // main sequence
    //--------------------
    initial begin
        seed         = 47026;
        err_cnt      = 0;
        chk_cnt      = 0;
        test_cnt     = 0;
        test_err0    = 0;
        arst_n_i     = 1'b0;
        spi_sclk_i   = 1'b0;
        spi_cs_i     = 2'b11;
        spi_mosi_i   = 1'b0;
        flash_miso_i = 1'b0;
        temp_i       = '0;
        link_i       = '0;
        mdio_i       = 1'b0;
        for (int a = 0; a < (1 << REG_AW); a++) begin
            model_mem[a] = '0;
        end
        wait_cycles(10);
        arst_n_i = 1'b1;
        test_led();
        test_reset_reads();
        test_write_read();
        test_bad_writes();
        test_abort();
        test_flash_miso();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/board_ctrl_top.sv */
//--------------------
// board control top
// spi register port, shared miso with flash, debug led
//--------------------
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_top
    import board_ctrl_pkg::*;
(
    input  wire                  reg_clk,
    input  wire                  arst_n_i,
    input  wire                  spi_sclk_i,
    input  wire  [1:0]           spi_cs_i,      // [1] reg port, [0] flash
    input  wire                  spi_mosi_i,
    input  wire                  flash_miso_i,
    input  wire  [TEMP_W-1:0]    temp_i,
    input  wire  [ETH_PORTS-1:0] link_i,
    input  wire                  mdio_i,
    output logic                 spi_miso_o,
    output logic                 flash_cs_o,
    output logic                 flash_mosi_o,
    output logic [ETH_PORTS-1:0] eth_phy_rst_o,
    output logic                 mdc_o,
    output logic                 mdio_o,
    output logic                 mdio_oe_o,
    output logic                 dbg_led_o
);

    logic                sel;
    logic                rise;
    logic [CMD_BITS-1:0] rx_byte;
    logic                load;
    logic [REG_DW-1:0]   load_data;
    logic [REG_AW-1:0]   rd_addr;
    logic [REG_DW-1:0]   rd_data;
    logic                reg_miso;
    reg_wr_t             wr;
    phy_ctrl_t           phy;

    //--------------------
    // spi register port
    //--------------------
    spi_shifter u_shifter (
        .reg_clk     (reg_clk),
        .arst_n_i    (arst_n_i),
        .sclk_i      (spi_sclk_i),
        .cs_n_i      (spi_cs_i[1]),
        .mosi_i      (spi_mosi_i),
        .load_i      (load),
        .load_data_i (load_data),
        .miso_o      (reg_miso),
        .sel_o       (sel),
        .rise_o      (rise),
        .rx_byte_o   (rx_byte)
    );

    spi_frame_ctrl u_frame_ctrl (
        .reg_clk     (reg_clk),
        .arst_n_i    (arst_n_i),
        .sel_i       (sel),
        .rise_i      (rise),
        .rx_byte_i   (rx_byte),
        .rd_data_i   (rd_data),
        .load_o      (load),
        .load_data_o (load_data),
        .rd_addr_o   (rd_addr),
        .wr_o        (wr)
    );

    reg_file u_reg_file (
        .reg_clk   (reg_clk),
        .arst_n_i  (arst_n_i),
        .wr_i      (wr),
        .rd_addr_i (rd_addr),
        .temp_i    (temp_i),
        .link_i    (link_i),
        .mdio_i    (mdio_i),
        .rd_data_o (rd_data),
        .phy_o     (phy)
    );

    led_blinker u_led (
        .reg_clk  (reg_clk),
        .arst_n_i (arst_n_i),
        .led_o    (dbg_led_o)
    );

    // flash shares sclk and mosi, a deselected device reads as 1
    assign flash_cs_o   = spi_cs_i[0];
    assign flash_mosi_o = spi_mosi_i;
    assign spi_miso_o   = (flash_miso_i | spi_cs_i[0]) & (reg_miso | spi_cs_i[1]);

    assign eth_phy_rst_o = phy.phy_rst;
    assign mdc_o         = phy.mdc;
    assign mdio_o        = phy.mdio_out;
    assign mdio_oe_o     = phy.mdio_oe;

endmodule

`default_nettype wire

/* verilog/led_blinker.sv */
//--------------------
// debug led blinker
//--------------------
`timescale 1ns/10ps
`default_nettype none

module led_blinker
    import board_ctrl_pkg::*;
(
    input  wire  reg_clk,
    input  wire  arst_n_i,
    output logic led_o
);

    logic [LED_CNT_W-1:0] cnt_q;
    logic                 led_q;
    logic                 cnt_wrap;

    assign cnt_wrap = (cnt_q == LED_CNT_W'(LED_HALF_PERIOD - 1));

    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
            led_q <= 1'b0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
            led_q <= ~led_q;  // half period done
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign led_o = led_q;

    a_cnt_range: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        cnt_q < LED_CNT_W'(LED_HALF_PERIOD))
        else $error("blink counter out of range");

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
//--------------------
// board register file
// phy and mdio controls, test array, read mux
//--------------------
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import board_ctrl_pkg::*;
(
    input  wire                  reg_clk,
    input  wire                  arst_n_i,
    input  wire reg_wr_t         wr_i,
    input  wire  [REG_AW-1:0]    rd_addr_i,
    input  wire  [TEMP_W-1:0]    temp_i,
    input  wire  [ETH_PORTS-1:0] link_i,
    input  wire                  mdio_i,
    output logic [REG_DW-1:0]    rd_data_o,
    output phy_ctrl_t            phy_o
);

    phy_ctrl_t         phy_q;
    logic [REG_DW-1:0] test_q [TEST_ARRAY_LEN];
    logic [REG_AW-1:0] wr_off;
    logic [REG_AW-1:0] rd_off;

    // true inside the test array window
    function automatic logic test_hit(input logic [REG_AW-1:0] addr);
        logic [REG_AW-1:0] off;
        off = addr - RA_TEST_BASE;
        return (addr >= RA_TEST_BASE) && (off < REG_AW'(TEST_ARRAY_LEN));
    endfunction

    assign wr_off = wr_i.addr - RA_TEST_BASE;
    assign rd_off = rd_addr_i - RA_TEST_BASE;

    //--------------------
    // writes
    //--------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phy_q <= '0;
            for (int i = 0; i < TEST_ARRAY_LEN; i++) begin
                test_q[i] <= '0;
            end
        end else if (wr_i.strobe) begin
            case (wr_i.addr)
                RA_PHY_RST:  phy_q.phy_rst  <= wr_i.data[ETH_PORTS-1:0];
                RA_MDC:      phy_q.mdc      <= wr_i.data[0];
                RA_MDIO_OUT: phy_q.mdio_out <= wr_i.data[0];
                RA_MDIO_DIR: phy_q.mdio_oe  <= wr_i.data[0];
                default: begin
                    // read-only and unmapped addresses fall out here
                    if (test_hit(wr_i.addr)) begin
                        test_q[wr_off[TEST_IDX_W-1:0]] <= wr_i.data;
                    end
                end
            endcase
        end
    end

    //--------------------
    // read mux
    //--------------------
    always_comb begin
        rd_data_o = '0;
        case (rd_addr_i)
            RA_FW_DATE_LO: rd_data_o = FW_DATE[15:0];
            RA_FW_DATE_HI: rd_data_o = FW_DATE[31:16];
            RA_FW_TIME_LO: rd_data_o = FW_TIME[15:0];
            RA_FW_TIME_HI: rd_data_o = FW_TIME[31:16];
            RA_FW_TYPE:    rd_data_o = FW_TYPE;
            RA_TEMP:       rd_data_o = REG_DW'(temp_i);
            RA_LINK:       rd_data_o = REG_DW'(link_i);
            RA_PHY_RST:    rd_data_o = REG_DW'(phy_q.phy_rst);
            RA_MDC:        rd_data_o = REG_DW'(phy_q.mdc);
            RA_MDIO_OUT:   rd_data_o = REG_DW'(phy_q.mdio_out);
            RA_MDIO_DIR:   rd_data_o = REG_DW'(phy_q.mdio_oe);
            RA_MDIO_IN:    rd_data_o = REG_DW'(mdio_i);  // raw pin level
            default: begin
                if (test_hit(rd_addr_i)) begin
                    rd_data_o = test_q[rd_off[TEST_IDX_W-1:0]];
                end
            end
        endcase
    end

    assign phy_o = phy_q;

endmodule

`default_nettype wire

/* verilog/spi_reg_port/spi_frame_ctrl.sv */
//--------------------
// spi frame control
// decodes command and data bits into read loads and write strobes
//--------------------
`timescale 1ns/10ps
`default_nettype none

module spi_frame_ctrl
    import board_ctrl_pkg::*;
(
    input  wire                 reg_clk,
    input  wire                 arst_n_i,
    input  wire                 sel_i,
    input  wire                 rise_i,
    input  wire  [CMD_BITS-1:0] rx_byte_i,
    input  wire  [REG_DW-1:0]   rd_data_i,
    output logic                load_o,
    output logic [REG_DW-1:0]   load_data_o,
    output logic [REG_AW-1:0]   rd_addr_o,
    output reg_wr_t             wr_o
);

    typedef enum logic [1:0] {
        ST_IDLE,  // no bits yet
        ST_CMD,
        ST_DATA,
        ST_DONE   // frame complete, extra bits ignored
    } state_t;

    state_t                         state_q;
    logic [BIT_CNT_W-1:0]           bit_cnt_q;
    logic [CMD_BITS-1:0]            cmd_q;
    logic [DATA_BITS-CMD_BITS-1:0]  data_hi_q;
    logic [DATA_BITS-1:0]           wr_data_q;
    logic                           load_q;
    logic                           wr_strobe_q;
    logic                           rd_frame_q;  // read load seen in this frame
    logic                           bit_tick;
    logic                           cmd_last;
    logic                           hi_last;
    logic                           frame_last;

    assign bit_tick   = sel_i && rise_i && (state_q != ST_DONE);
    assign cmd_last   = bit_tick && (state_q == ST_CMD)
                        && (bit_cnt_q == BIT_CNT_W'(CMD_BITS - 1));
    assign hi_last    = bit_tick && (state_q == ST_DATA)
                        && (bit_cnt_q == BIT_CNT_W'(2 * CMD_BITS - 1));
    assign frame_last = bit_tick && (state_q == ST_DATA)
                        && (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));

    //--------------------
    // control fsm
    //--------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_IDLE;
            bit_cnt_q   <= '0;
            cmd_q       <= '0;
            load_q      <= 1'b0;
            wr_strobe_q <= 1'b0;
        end else begin
            load_q      <= 1'b0;
            wr_strobe_q <= 1'b0;
            if (!sel_i) begin
                state_q   <= ST_IDLE;  // abort, partial frame is dropped
                bit_cnt_q <= '0;
            end else if (bit_tick) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (cmd_last) begin
                    cmd_q   <= rx_byte_i;
                    state_q <= ST_DATA;
                    load_q  <= rx_byte_i[CMD_BITS-1];  // read flag
                end else if (frame_last) begin
                    state_q     <= ST_DONE;
                    wr_strobe_q <= ~cmd_q[CMD_BITS-1];
                end else if (state_q == ST_IDLE) begin
                    state_q <= ST_CMD;
                end
            end
        end
    end

    // write data collected in two bytes
    always_ff @(posedge reg_clk) begin
        if (hi_last) begin
            data_hi_q <= rx_byte_i;
        end
        if (frame_last) begin
            wr_data_q <= {data_hi_q, rx_byte_i};
        end
    end

    // marks a frame that already issued a read load
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_frame_q <= 1'b0;
        end else if (!sel_i) begin
            rd_frame_q <= 1'b0;
        end else if (load_q) begin
            rd_frame_q <= 1'b1;
        end
    end

    assign rd_addr_o   = cmd_q[REG_AW-1:0];
    assign load_o      = load_q;
    assign load_data_o = rd_data_i;  // valid the cycle after cmd latch
    assign wr_o        = '{strobe: wr_strobe_q, addr: cmd_q[REG_AW-1:0], data: wr_data_q};

    a_wr_single: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        wr_o.strobe |=> !wr_o.strobe)
        else $error("write strobe longer than one cycle");

    a_wr_not_read: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        wr_o.strobe |-> !rd_frame_q)
        else $error("write strobe in a read frame");

endmodule

`default_nettype wire

/* verilog/spi_reg_port/spi_shifter.sv */
//--------------------
// spi pin synchronizer and bit shifter
// mode 0, rx byte on sclk rise, tx word on sclk fall
//--------------------
`timescale 1ns/10ps
`default_nettype none

module spi_shifter
    import board_ctrl_pkg::*;
(
    input  wire                 reg_clk,
    input  wire                 arst_n_i,
    input  wire                 sclk_i,
    input  wire                 cs_n_i,
    input  wire                 mosi_i,
    input  wire                 load_i,
    input  wire  [REG_DW-1:0]   load_data_i,
    output logic                miso_o,
    output logic                sel_o,
    output logic                rise_o,
    output logic [CMD_BITS-1:0] rx_byte_o
);

    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

    spi_pins_t                   pins_in;
    spi_pins_t [SYNC_STAGES-1:0] sync_q;
    spi_pins_t                   pins_s;   // synchronized pins
    logic                        sclk_d;
    logic                        rise_det;
    logic                        fall_det;
    logic                        sel_s;
    logic                        rise_q;
    logic                        sel_q;
    logic                        hold_q;
    logic [REG_DW-1:0]           tx_q;
    logic [CMD_BITS-1:0]         rx_q;

    assign pins_in  = '{sclk: sclk_i, cs_n: cs_n_i, mosi: mosi_i};
    assign pins_s   = sync_q[SYNC_STAGES-1];
    assign sel_s    = ~pins_s.cs_n;
    assign rise_det = pins_s.sclk & ~sclk_d;
    assign fall_det = ~pins_s.sclk & sclk_d;

    //--------------------
    // synchronizer and edge detect
    //--------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
            end
            sclk_d <= 1'b0;
            rise_q <= 1'b0;
            sel_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], pins_in};
            sclk_d <= pins_s.sclk;
            rise_q <= rise_det & sel_s;  // lines up with rx_q update
            sel_q  <= sel_s;
        end
    end

    // receive byte, msb first
    always_ff @(posedge reg_clk) begin
        if (rise_det && sel_s) begin
            rx_q <= {rx_q[CMD_BITS-2:0], pins_s.mosi};
        end
    end

    //--------------------
    // transmit word
    //--------------------
    // the fall right after a load keeps bit 15 on miso so the
    // master samples it on the next rise
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_q   <= '1;
            hold_q <= 1'b0;
        end else if (!sel_s) begin
            tx_q   <= '1;  // idle high
            hold_q <= 1'b0;
        end else if (load_i) begin
            tx_q   <= load_data_i;
            hold_q <= 1'b1;
        end else if (fall_det) begin
            if (hold_q) begin
                hold_q <= 1'b0;
            end else begin
                tx_q <= {tx_q[REG_DW-2:0], 1'b1};
            end
        end
    end

    assign miso_o    = tx_q[REG_DW-1];
    assign sel_o     = sel_q;
    assign rise_o    = rise_q;
    assign rx_byte_o = rx_q;

    a_rise_in_frame: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        rise_o |-> sel_o)
        else $error("sclk rise reported outside a selected frame");

endmodule

`default_nettype wire

/* common/board_ctrl_pkg.sv */
//--------------------
// board control package
// register map, frame sizes and shared structs
//--------------------
`default_nettype none

package board_ctrl_pkg;

    //--------------------
    // sizes
    //--------------------
    localparam int REG_DW          = 16;
    localparam int REG_AW          = 7;   // eighth command bit is the read flag
    localparam int CMD_BITS        = 8;
    localparam int DATA_BITS       = 16;
    localparam int FRAME_BITS      = CMD_BITS + DATA_BITS;
    localparam int BIT_CNT_W       = $clog2(FRAME_BITS + 1);
    localparam int SYNC_STAGES     = 2;   // pin synchronizer depth
    localparam int ETH_PORTS       = 4;
    localparam int TEMP_W          = 12;
    localparam int TEST_ARRAY_LEN  = 8;
    localparam int TEST_IDX_W      = $clog2(TEST_ARRAY_LEN);

    // firmware identification
    localparam logic [31:0] FW_DATE = 32'h5A17_0C21;
    localparam logic [31:0] FW_TIME = 32'h0013_4507;
    localparam logic [15:0] FW_TYPE = 16'h0B41;

    // simulation scale, raise for hardware
    localparam int LED_HALF_PERIOD = 1000;
    localparam int LED_CNT_W       = $clog2(LED_HALF_PERIOD);

    //--------------------
    // register addresses
    //--------------------
    localparam logic [REG_AW-1:0] RA_FW_DATE_LO = 7'h00;
    localparam logic [REG_AW-1:0] RA_FW_DATE_HI = 7'h01;
    localparam logic [REG_AW-1:0] RA_FW_TIME_LO = 7'h02;
    localparam logic [REG_AW-1:0] RA_FW_TIME_HI = 7'h03;
    localparam logic [REG_AW-1:0] RA_FW_TYPE    = 7'h04;
    localparam logic [REG_AW-1:0] RA_TEMP       = 7'h05;
    localparam logic [REG_AW-1:0] RA_LINK       = 7'h06;
    localparam logic [REG_AW-1:0] RA_PHY_RST    = 7'h07;
    localparam logic [REG_AW-1:0] RA_MDC        = 7'h08;
    localparam logic [REG_AW-1:0] RA_MDIO_OUT   = 7'h09;
    localparam logic [REG_AW-1:0] RA_MDIO_DIR   = 7'h0A;
    localparam logic [REG_AW-1:0] RA_MDIO_IN    = 7'h0B;
    localparam logic [REG_AW-1:0] RA_TEST_BASE  = 7'h10;  // 8 entries up to 0x17

    //--------------------
    // structs
    //--------------------
    typedef struct packed {
        logic              strobe;  // one cycle per write frame
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [ETH_PORTS-1:0] phy_rst;
        logic                 mdc;
        logic                 mdio_out;
        logic                 mdio_oe;  // high drives the mdio pin
    } phy_ctrl_t;

endpackage

`default_nettype wire
